//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_nabp_shift
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
src/nabp_cfg_pkg.sv
src/nabp_types_pkg.sv
src/shift_cmd_if.sv
src/apb_shift_regs.sv
src/line_shifter.sv
src/filter_mapper.sv
src/nabp_shift_top.sv
tb/tb_nabp_shift.sv

//--- src/apb_shift_regs.sv
`timescale 1ns/1ps

module apb_shift_regs
    import nabp_cfg_pkg::*;
    import nabp_types_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    shift_cmd_if.regs         cmd
);

    localparam int STEP_W = $bits(cmd.accu_step);

    logic              access;
    logic              addr_ok;
    logic              wr_ctrl;
    logic              wr_step;
    logic              fill_done_flag;
    logic              shift_done_flag;
    logic [APB_DW-1:0] status_word;

    // access phase completes in one cycle
    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_STEP) || (paddr == REG_STATUS);
    assign wr_ctrl = access && pwrite && (paddr == REG_CTRL);
    assign wr_step = access && pwrite && (paddr == REG_STEP);

    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    // kicks land on the interface the cycle after the access phase
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cmd.fill_kick  <= 1'b0;
            cmd.shift_kick <= 1'b0;
        end
        else
        begin
            cmd.fill_kick  <= wr_ctrl && pwdata[CTRL_FILL_BIT];
            cmd.shift_kick <= wr_ctrl && pwdata[CTRL_SHIFT_BIT];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            cmd.accu_step <= '0;
        else if (wr_step)
            cmd.accu_step <= pwdata[STEP_W-1:0];
    end

    // done flags hold until the shifter takes a kick of the same kind
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_done_flag  <= 1'b0;
            shift_done_flag <= 1'b0;
        end
        else
        begin
            if (cmd.fill_done)
                fill_done_flag <= 1'b1;
            else if (cmd.fill_kick && cmd.state == st_ready)
                fill_done_flag <= 1'b0;

            if (cmd.shift_done)
                shift_done_flag <= 1'b1;
            else if (cmd.shift_kick && cmd.state == st_fill_done)
                shift_done_flag <= 1'b0;
        end
    end

    always_comb
    begin
        status_word = '0;
        status_word[STATUS_FILL_DONE_BIT]  = fill_done_flag;
        status_word[STATUS_SHIFT_DONE_BIT] = shift_done_flag;
        status_word[STATUS_STATE_LSB +: $bits(shifter_state_t)] = cmd.state;
    end

    // ctrl is write-only, reads back as zero
    always_comb
    begin
        case (paddr)
            REG_STEP:   prdata = APB_DW'(cmd.accu_step);
            REG_STATUS: prdata = status_word;
            default:    prdata = '0;
        endcase
    end

    // error response only inside an access phase
    assert property (@(posedge clk) disable iff (!reset_n)
        pslverr |-> (psel && penable));

endmodule

//--- src/filter_mapper.sv
`timescale 1ns/1ps

module filter_mapper
#(
    parameter int MAP_DEPTH = nabp_cfg_pkg::MAP_DEPTH,
    parameter int SAMPLE_W  = nabp_cfg_pkg::SAMPLE_W
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mapper_kick,
    input  logic                shift_en,
    input  logic [SAMPLE_W-1:0] sample_in,
    output logic [SAMPLE_W-1:0] tap_out,
    output logic                tap_valid
);

    logic [SAMPLE_W-1:0] stage [MAP_DEPTH];

    // stage 0 is the newest sample, the last stage the oldest
    always_ff @(posedge clk)
    begin
        if (mapper_kick)
        begin
            for (int i = 0; i < MAP_DEPTH; i++)
                stage[i] <= '0;
        end
        else if (shift_en)
        begin
            stage[0] <= sample_in;
            for (int i = 1; i < MAP_DEPTH; i++)
                stage[i] <= stage[i-1];
        end
    end

    // capture what falls off the end
    always_ff @(posedge clk)
    begin
        if (shift_en)
            tap_out <= stage[MAP_DEPTH-1];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            tap_valid <= 1'b0;
        else
            tap_valid <= shift_en;
    end

    // one strobe per shift, one cycle later
    assert property (@(posedge clk) disable iff (!reset_n)
        tap_valid == $past(shift_en));

endmodule

//--- src/line_shifter.sv
`timescale 1ns/1ps

module line_shifter
    import nabp_types_pkg::*;
#(
    parameter int IMAGE_SIZE = nabp_cfg_pkg::IMAGE_SIZE,
    parameter int FILL_COUNT = nabp_cfg_pkg::FILL_COUNT,
    parameter int ACCU_W     = nabp_cfg_pkg::ACCU_W,
    parameter int FRAC_W     = nabp_cfg_pkg::FRAC_W
)
(
    input  logic         clk,
    input  logic         reset_n,
    shift_cmd_if.shifter cmd,
    output logic         shift_en,
    output logic         mapper_kick
);

    localparam int FILL_CW = $clog2(FILL_COUNT + 1);
    localparam int STEP_CW = $clog2(IMAGE_SIZE);
    localparam logic [FILL_CW-1:0] FILL_LAST = FILL_CW'(FILL_COUNT - 1);
    localparam logic [STEP_CW-1:0] STEP_LAST = STEP_CW'(IMAGE_SIZE - 2);

    shifter_state_t     state;
    shifter_state_t     next_state;
    logic [FILL_CW-1:0] fill_cnt;
    logic [STEP_CW-1:0] step_cnt;
    logic [ACCU_W-1:0]  accu_prev;
    logic [ACCU_W-1:0]  accu_cur;
    logic               fill_last;
    logic               step_last;
    logic               crossing;

    // accu_prev holds (i-1)*step, accu_cur is i*step, wrapping freely
    assign accu_cur = accu_prev + cmd.accu_step;
    assign crossing = accu_cur[ACCU_W-1:FRAC_W] != accu_prev[ACCU_W-1:FRAC_W];

    assign fill_last = (state == st_fill) && (fill_cnt == FILL_LAST);
    assign step_last = (state == st_shift) && (step_cnt == STEP_LAST);

    // mealy outputs
    assign shift_en       = (state == st_fill) || ((state == st_shift) && crossing);
    assign mapper_kick    = (state == st_ready) && cmd.fill_kick;
    assign cmd.fill_done  = fill_last;
    assign cmd.shift_done = step_last;
    assign cmd.state      = state;

    always_comb
    begin
        next_state = state;
        case (state)
            st_ready:
                if (cmd.fill_kick)
                    next_state = st_fill;
            st_fill:
                if (fill_last)
                    next_state = st_fill_done;
            st_fill_done:
                if (cmd.shift_kick)
                    next_state = st_shift;
            st_shift:
                if (step_last)
                    next_state = st_ready;
            default:
                next_state = st_ready;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= st_ready;
        else
            state <= next_state;
    end

    // counters and accumulator rewind whenever their phase is not active
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt  <= '0;
            step_cnt  <= '0;
            accu_prev <= '0;
        end
        else
        begin
            if (state == st_fill)
                fill_cnt <= fill_cnt + 1'b1;
            else
                fill_cnt <= '0;

            if (state == st_shift)
            begin
                step_cnt  <= step_cnt + 1'b1;
                accu_prev <= accu_cur;
            end
            else
            begin
                step_cnt  <= '0;
                accu_prev <= '0;
            end
        end
    end

    // mapper stays still while idle or waiting for the shift command
    assert property (@(posedge clk) disable iff (!reset_n)
        (state == st_ready || state == st_fill_done) |-> !shift_en);

    assert property (@(posedge clk) disable iff (!reset_n)
        !(cmd.fill_done && cmd.shift_done));

endmodule

//--- src/nabp_cfg_pkg.sv
package nabp_cfg_pkg;

    // line and partition geometry
    localparam int IMAGE_SIZE = 16;
    localparam int FILL_COUNT = 4;
    localparam int MAP_DEPTH  = 4;

    // accumulator fixed point, integer part sits above FRAC_W
    localparam int ACCU_W = 16;
    localparam int FRAC_W = 8;

    localparam int SAMPLE_W = 12;

    // apb bus geometry
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register byte offsets
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] REG_STEP   = 8'h04;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;

    // ctrl write bits
    localparam int CTRL_FILL_BIT  = 0;
    localparam int CTRL_SHIFT_BIT = 1;

endpackage

//--- src/nabp_shift_top.sv
`timescale 1ns/1ps

module nabp_shift_top
    import nabp_cfg_pkg::*;
#(
    parameter int IMAGE_SIZE = nabp_cfg_pkg::IMAGE_SIZE,
    parameter int FILL_COUNT = nabp_cfg_pkg::FILL_COUNT,
    parameter int MAP_DEPTH  = nabp_cfg_pkg::MAP_DEPTH,
    parameter int ACCU_W     = nabp_cfg_pkg::ACCU_W,
    parameter int FRAC_W     = nabp_cfg_pkg::FRAC_W,
    parameter int SAMPLE_W   = nabp_cfg_pkg::SAMPLE_W
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic [APB_AW-1:0]   paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [APB_DW-1:0]   pwdata,
    output logic [APB_DW-1:0]   prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic [SAMPLE_W-1:0] sample_in,
    output logic [SAMPLE_W-1:0] tap_out,
    output logic                tap_valid
);

    logic shift_en;
    logic mapper_kick;

    shift_cmd_if #(.ACCU_W(ACCU_W)) cmd_if ();

    // host side
    apb_shift_regs regs_i (
        .clk     (clk),
        .reset_n (reset_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd_if)
    );

    line_shifter #(
        .IMAGE_SIZE (IMAGE_SIZE),
        .FILL_COUNT (FILL_COUNT),
        .ACCU_W     (ACCU_W),
        .FRAC_W     (FRAC_W)
    ) shifter_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd         (cmd_if),
        .shift_en    (shift_en),
        .mapper_kick (mapper_kick)
    );

    // sample path, tap goes straight out
    filter_mapper #(
        .MAP_DEPTH (MAP_DEPTH),
        .SAMPLE_W  (SAMPLE_W)
    ) mapper_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .mapper_kick (mapper_kick),
        .shift_en    (shift_en),
        .sample_in   (sample_in),
        .tap_out     (tap_out),
        .tap_valid   (tap_valid)
    );

endmodule

//--- src/nabp_types_pkg.sv
package nabp_types_pkg;

    // shifter phases, ready encodes as zero
    typedef enum logic [1:0] {
        st_ready     = 2'd0,
        st_fill      = 2'd1,
        st_fill_done = 2'd2,
        st_shift     = 2'd3
    } shifter_state_t;

    // status register layout
    localparam int STATUS_FILL_DONE_BIT  = 0;
    localparam int STATUS_SHIFT_DONE_BIT = 1;

    // state field occupies bits 3:2
    localparam int STATUS_STATE_LSB = 2;

endpackage

//--- src/shift_cmd_if.sv
`timescale 1ns/1ps

interface shift_cmd_if
    import nabp_types_pkg::*;
#(
    parameter int ACCU_W = nabp_cfg_pkg::ACCU_W
);

    // commands from the register block
    logic              fill_kick;
    logic              shift_kick;
    logic [ACCU_W-1:0] accu_step;

    // completion pulses and phase from the shifter
    logic              fill_done;
    logic              shift_done;
    shifter_state_t    state;

    modport regs (
        output fill_kick, shift_kick, accu_step,
        input  fill_done, shift_done, state
    );

    modport shifter (
        input  fill_kick, shift_kick, accu_step,
        output fill_done, shift_done, state
    );

endinterface

//--- tb/tb_nabp_shift.sv
`timescale 1ns/1ps

module tb_nabp_shift
    import nabp_cfg_pkg::*;
    import nabp_types_pkg::*;
();

    localparam int TEST_COUNT      = 9;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (IMAGE_SIZE + FILL_COUNT + 40);
    localparam int POLL_MAX        = IMAGE_SIZE + FILL_COUNT;
    localparam int IDLE_WINDOW     = FILL_COUNT + 8;
    localparam logic [APB_AW-1:0] REG_BAD = 8'h0C;

    logic                clk = 1'b0;
    logic                reset_n;
    logic [APB_AW-1:0]   paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic [SAMPLE_W-1:0] sample_in = '0;
    logic [SAMPLE_W-1:0] tap_out;
    logic                tap_valid;

    int seed = 13583;
    logic [ACCU_W-1:0] steps [4] = '{16'h0080, 16'h0155, 16'h0100, 16'h0400};

    // reference model state kept by the monitor
    logic [SAMPLE_W-1:0] model_q [$];
    logic [SAMPLE_W-1:0] prev_sample = '0;
    int flush_req   = 0;
    int flush_ack   = 0;
    int strobe_cnt  = 0;
    int exp_strobes = 0;
    int tap_errors  = 0;
    int idle_errors = 0;
    int errors      = 0;
    int pass_cnt    = 0;
    int fail_cnt    = 0;
    logic quiet     = 1'b1;

    nabp_shift_top dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .sample_in (sample_in),
        .tap_out   (tap_out),
        .tap_valid (tap_valid)
    );

    always #50 clk = ~clk;

    // fresh sample every cycle
    always @(negedge clk)
        sample_in = SAMPLE_W'($random(seed));

    // tap_out lags the accepted samples by MAP_DEPTH strobes
    always @(posedge clk)
    begin
        logic [SAMPLE_W-1:0] expected;
        if (flush_req != flush_ack)
        begin
            model_q.delete();
            flush_ack = flush_req;
        end
        if (tap_valid)
        begin
            expected = '0;
            if (model_q.size() >= MAP_DEPTH)
                expected = model_q.pop_front();
            model_q.push_back(prev_sample);
            strobe_cnt++;
            assert (tap_out == expected)
            else
            begin
                tap_errors++;
                $display("mismatch tap_out: got 0x%0h expected 0x%0h", tap_out, expected);
            end
        end
        prev_sample = sample_in;
    end

    // no strobe while the shifter should sit still
    assert property (@(posedge clk) disable iff (!reset_n) quiet |-> !tap_valid)
    else
    begin
        idle_errors++;
        $display("tap_valid strobe seen while the shifter should be idle");
    end

    function automatic int total_errors();
        return errors + tap_errors + idle_errors;
    endfunction

    function automatic void check_equal(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endfunction

    // integer part of i*step against (i-1)*step wrapped to ACCU_W
    function automatic int expected_crossings(input logic [ACCU_W-1:0] step);
        logic [ACCU_W-1:0] cur;
        logic [ACCU_W-1:0] prev;
        int count;
        count = 0;
        for (int i = 1; i < IMAGE_SIZE; i++)
        begin
            cur  = ACCU_W'(i * step);
            prev = ACCU_W'((i - 1) * step);
            if ((cur >> FRAC_W) != (prev >> FRAC_W))
                count++;
        end
        return count;
    endfunction

    // called and returns just after a falling edge
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] wdata,
                              output logic [APB_DW-1:0] rdata, output logic err);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        check_equal("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] rd;
        logic err;
        apb_access(1'b1, addr, data, rd, err);
        check_equal("pslverr", 32'(err), 32'h0);
    endtask

    task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_equal("pslverr", 32'(err), 32'h0);
    endtask

    task automatic wait_status_bit(input int bit_idx, output logic [APB_DW-1:0] status);
        int polls;
        polls = 0;
        read_reg(REG_STATUS, status);
        while (!status[bit_idx] && polls < POLL_MAX)
        begin
            read_reg(REG_STATUS, status);
            polls++;
        end
        assert (status[bit_idx])
        else
        begin
            errors++;
            $display("status bit %0d never set within %0d reads", bit_idx, POLL_MAX);
        end
    endtask

    task automatic check_ignored_kick(input logic [APB_DW-1:0] ctrl);
        logic [APB_DW-1:0] status_pre;
        logic [APB_DW-1:0] status_post;
        int start;
        read_reg(REG_STATUS, status_pre);
        start = strobe_cnt;
        write_reg(REG_CTRL, ctrl);
        repeat (IDLE_WINDOW) @(negedge clk);
        read_reg(REG_STATUS, status_post);
        check_equal("status", status_post, status_pre);
        check_equal("strobe count", 32'(strobe_cnt - start), 32'h0);
    endtask

    task automatic run_fill();
        logic [APB_DW-1:0] status;
        int start;
        // mapper clears on this kick
        flush_req++;
        start = strobe_cnt;
        write_reg(REG_CTRL, 32'h1);
        wait_status_bit(STATUS_FILL_DONE_BIT, status);
        check_equal("fill strobes", 32'(strobe_cnt - start), 32'(FILL_COUNT));
        check_equal("state", 32'(status[STATUS_STATE_LSB +: 2]), 32'(st_fill_done));
        exp_strobes += FILL_COUNT;
    endtask

    task automatic run_shift(input logic [ACCU_W-1:0] step);
        logic [APB_DW-1:0] status;
        int start;
        int crossings;
        crossings = expected_crossings(step);
        write_reg(REG_STEP, 32'(step));
        start = strobe_cnt;
        write_reg(REG_CTRL, 32'h2);
        wait_status_bit(STATUS_SHIFT_DONE_BIT, status);
        check_equal("shift strobes", 32'(strobe_cnt - start), 32'(crossings));
        check_equal("state", 32'(status[STATUS_STATE_LSB +: 2]), 32'(st_ready));
        exp_strobes += crossings;
    endtask

    task automatic finish_test(input string name, input int err_mark);
        if (total_errors() == err_mark)
        begin
            pass_cnt++;
            $display("test %s passed", name);
        end
        else
        begin
            fail_cnt++;
            $display("test %s failed", name);
        end
    endtask

    initial
    begin
        logic [APB_DW-1:0] rd;
        logic err;
        int mark;
        reset_n = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        mark = total_errors();
        read_reg(REG_STATUS, rd);
        check_equal("status", rd, 32'h0);
        repeat (4) @(negedge clk);
        finish_test("reset", mark);

        mark = total_errors();
        write_reg(REG_STEP, 32'h0000_a5c3);
        read_reg(REG_STEP, rd);
        check_equal("step", rd, 32'h0000_a5c3);
        apb_access(1'b0, REG_BAD, '0, rd, err);
        check_equal("pslverr", 32'(err), 32'h1);
        finish_test("register access", mark);

        // shift kick while ready
        mark = total_errors();
        check_ignored_kick(32'h2);
        finish_test("wrong-state kick", mark);

        mark = total_errors();
        quiet = 1'b0;
        run_fill();
        quiet = 1'b1;
        check_ignored_kick(32'h1);
        finish_test("fill", mark);

        quiet = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            mark = total_errors();
            if (i != 0)
                run_fill();
            run_shift(steps[i]);
            finish_test($sformatf("shift step 0x%04h", steps[i]), mark);
        end

        mark = total_errors() - tap_errors;
        check_equal("tap strobes", 32'(strobe_cnt), 32'(exp_strobes));
        finish_test("data order", mark);

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errors() == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
